/* flist.f */
logic/fetch_pkg.sv
logic/bpu_pkg.sv
logic/static_bpu.sv
logic/imem_arbiter.sv
logic/inst_mem.sv
logic/fetch_pc_gen.sv
logic/frontend_top.sv
dv/frontend_assertions.sv
dv/frontend_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the front end testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module frontend_tb -o frontend_sim

out=$(./obj_dir/frontend_sim)
echo "$out"

if echo "$out" | grep -q "Test completed successfully"; then
    exit 0
fi
exit 1

/* dv/frontend_tb.sv */
// Testbench for the two-wide fetch front end, fetch starts at pc 0.
// The program goes in through the load port right after reset.
// Packets are sampled at the rising edge and compared with a static
// prediction model that follows every word seen on the load port.

`timescale 1ns/1ns
`default_nettype none

module frontend_tb;

    localparam fetch_pkg::addr_t RESET_PC = '0;
    localparam int IMEM_DEPTH  = 64;
    localparam int IDX_W       = $clog2(IMEM_DEPTH);
    localparam int FLOW_CYC    = 40;
    localparam int STALL_CYC   = 80;
    localparam int LOAD_CYC    = 40;
    localparam int TIMEOUT_CYC = 2 * (IMEM_DEPTH + FLOW_CYC + STALL_CYC + LOAD_CYC + 16);

    logic                  clk_i;
    logic                  rst_n_i;
    logic                  load_we_i;
    logic                  stall_i;
    fetch_pkg::addr_t      load_addr_i;
    fetch_pkg::inst_t      load_data_i;
    fetch_pkg::fetch_pkt_t pkt_o;
    logic                  pkt_valid_o;

    fetch_pkg::inst_t        prog [IMEM_DEPTH];       // image driven on the load port
    fetch_pkg::inst_t        model_mem [IMEM_DEPTH];  // what the RAM should hold
    fetch_pkg::addr_t        exp_pc = RESET_PC;
    fetch_pkg::fetch_pkt_t   exp_pkt;
    fetch_pkg::fetch_pkt_t   prev_pkt;
    logic [IMEM_DEPTH/2-1:0] seen = '0;  // packet seen, indexed by pc/8
    logic                    held_prev = 1'b0;
    logic                    exp_valid = 1'b0;  // packet due in this cycle
    int                      err_count, check_count, hold_count, drop_count, cycle_count;

    frontend_top #(
        .RESET_PC   (RESET_PC),
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_frontend_top (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .stall_i     (stall_i),
        .pkt_o       (pkt_o),
        .pkt_valid_o (pkt_valid_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;  // 8 ns period
    end

    function automatic fetch_pkg::inst_t enc_jal(input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], 5'd0, bpu_pkg::OPC_JAL};  // rd = x0
    endfunction

    function automatic fetch_pkg::inst_t enc_br(input int off, input logic [2:0] f3);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], 5'd2, 5'd1, f3, o[4:1], o[11], bpu_pkg::OPC_BRANCH};
    endfunction

    // expected packet at pc from the static rules
    function automatic fetch_pkg::fetch_pkt_t ref_pkt(input fetch_pkg::inst_t img [IMEM_DEPTH],
                                                      input fetch_pkg::addr_t pc);
        fetch_pkg::fetch_pkt_t p;
        fetch_pkg::inst_t      i0, i1;
        logic [IDX_W-1:0]      idx;
        logic [31:0]           boff0, boff1, joff0, joff1;
        logic                  jal0, br0, jal1, br1, tk0, from1;
        idx   = pc[IDX_W+1:2];
        i0    = img[idx];
        i1    = img[idx + IDX_W'(1)];  // pair wraps at the top
        boff0 = {{20{i0[31]}}, i0[7], i0[30:25], i0[11:8], 1'b0};
        boff1 = {{20{i1[31]}}, i1[7], i1[30:25], i1[11:8], 1'b0};
        joff0 = {{12{i0[31]}}, i0[19:12], i0[20], i0[30:21], 1'b0};
        joff1 = {{12{i1[31]}}, i1[19:12], i1[20], i1[30:21], 1'b0};
        jal0  = (i0[6:0] == bpu_pkg::OPC_JAL);
        br0   = (i0[6:0] == bpu_pkg::OPC_BRANCH) && boff0[31];  // backward only
        jal1  = !jal0 && (i1[6:0] == bpu_pkg::OPC_JAL);         // slot 1 dead behind JAL
        br1   = !jal0 && (i1[6:0] == bpu_pkg::OPC_BRANCH) && boff1[31];
        tk0   = jal0 || br0;
        from1 = !tk0 && (jal1 || br1);
        p.pc0        = pc;
        p.inst0      = i0;
        p.inst1      = i1;
        p.valid0     = 1'b1;
        p.valid1     = !tk0;
        p.pred_br0   = br0;
        p.pred_br1   = br1;
        p.pred_taken = tk0 || jal1 || br1;
        p.pred_slot  = from1;
        if (from1) begin
            p.pred_target = pc + 32'd4 + (br1 ? boff1 : joff1);
        end else if (tk0) begin
            p.pred_target = pc + (br0 ? boff0 : joff0);
        end else begin
            p.pred_target = pc + 32'd4;  // fall through of slot 0
        end
        return p;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            err_count++;
            $display("Mismatch %s at pc %h: got %h expected %h", name, exp_pc, got, exp);
        end
    endtask

    task automatic report_failure(input string what);
        err_count++;
        $display("error: %s", what);
    endtask

    // compare at the rising edge, inputs settled since the falling edge
    always @(posedge clk_i) begin
        if (rst_n_i) begin
            check_eq("pkt_valid_o", 32'(pkt_valid_o), 32'(exp_valid));
            if (held_prev && pkt_o !== prev_pkt) begin
                report_failure("pkt_o changed while stall_i was high");
            end
            if (load_we_i && !pkt_valid_o) drop_count++;
            if (pkt_valid_o) seen[pkt_o.pc0[IDX_W+1:3]] = 1'b1;  // path the DUT took
            if (exp_valid) begin
                exp_pkt = ref_pkt(model_mem, exp_pc);
                check_eq("pc0", pkt_o.pc0, exp_pkt.pc0);
                check_eq("inst0", pkt_o.inst0, exp_pkt.inst0);
                check_eq("inst1", pkt_o.inst1, exp_pkt.inst1);
                check_eq("valid0", 32'(pkt_o.valid0), 32'(exp_pkt.valid0));
                check_eq("valid1", 32'(pkt_o.valid1), 32'(exp_pkt.valid1));
                check_eq("pred_br0", 32'(pkt_o.pred_br0), 32'(exp_pkt.pred_br0));
                check_eq("pred_br1", 32'(pkt_o.pred_br1), 32'(exp_pkt.pred_br1));
                check_eq("pred_taken", 32'(pkt_o.pred_taken), 32'(exp_pkt.pred_taken));
                check_eq("pred_slot", 32'(pkt_o.pred_slot), 32'(exp_pkt.pred_slot));
                check_eq("pred_target", pkt_o.pred_target, exp_pkt.pred_target);
                if (stall_i) begin
                    hold_count++;  // same packet again next cycle
                end else begin
                    exp_pc = exp_pkt.pred_taken ? exp_pkt.pred_target : exp_pc + 32'd8;
                end
            end
            held_prev = exp_valid && stall_i;
            prev_pkt  = pkt_o;
            // held packet stays, a read issued now returns next cycle unless redirected
            exp_valid = (exp_valid && stall_i)
                      || (!stall_i && !load_we_i && !(exp_valid && exp_pkt.pred_taken));
        end
        if (load_we_i) model_mem[load_addr_i[IDX_W+1:2]] = load_data_i;  // RAM write lands now
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYC) begin
            $display("timeout after %0d cycles, stimulus never finished", cycle_count);
            $display("Test failed");
            $finish;
        end
    end

    initial begin
        int rnd;
        int errs_before;
        rnd         = $urandom(32'h8b33);
        rst_n_i     = 1'b0;
        load_we_i   = 1'b0;
        load_addr_i = '0;
        load_data_i = '0;
        stall_i     = 1'b0;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            prog[i] = 32'h13 | (32'(i) << 20);  // addi x0, x0, index
        end
        prog[8]  = enc_jal(32'h60);               // 0x20 -> 0x80, slot 0 JAL
        prog[10] = enc_jal(32'h78);               // 0x28 -> 0xa0
        prog[13] = enc_jal(32'h8c);               // slot 1 at 0x34 -> 0xc0
        prog[14] = enc_jal(32'ha8);               // 0x38 -> 0xe0, only after rewrite
        prog[32] = enc_br(32'h20, 3'b000);        // 0x80 forward beq, not taken
        prog[35] = enc_br(-32'sh64, 3'b000);      // slot 1 at 0x8c back to 0x28
        prog[40] = enc_br(-32'sh70, 3'b100);      // 0xa0 blt back to 0x30
        prog[41] = enc_jal(-32'sha4);             // loses to slot 0
        prog[49] = enc_br(32'h10, 3'b001);        // slot 1 forward bne
        prog[57] = enc_jal(-32'sh24);             // 0xe4 -> 0xc0, main loop
        repeat (4) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        for (int i = 0; i < IMEM_DEPTH; i++) begin
            load_we_i   = 1'b1;
            load_addr_i = 32'(i * 4);
            load_data_i = prog[i];
            @(negedge clk_i);
        end
        load_we_i = 1'b0;

        errs_before = err_count;
        repeat (FLOW_CYC) @(negedge clk_i);
        if (!(seen[0] && seen[4] && seen[16] && seen[5] && seen[20] && seen[6] && seen[28])) begin
            report_failure("fetch did not walk the expected packet chain");
        end
        $display("flow test done: %0d errors", err_count - errs_before);

        errs_before = err_count;
        repeat (STALL_CYC) begin
            stall_i = (($urandom % 3) == 0);
            @(negedge clk_i);
        end
        stall_i = 1'b0;
        repeat (4) @(negedge clk_i);
        if (hold_count == 0) report_failure("no packet was ever held under stall_i");
        $display("stall test done: %0d errors", err_count - errs_before);

        errs_before = err_count;
        drop_count  = 0;
        if (seen[7]) report_failure("0x38 fetched before the rewrite");
        load_we_i   = 1'b1;
        load_addr_i = 32'hf0;
        load_data_i = 32'h0f00_0013;
        @(negedge clk_i);
        load_addr_i = 32'hf4;
        load_data_i = 32'h0f40_0013;
        @(negedge clk_i);
        load_addr_i = 32'hf8;
        load_data_i = 32'h0f80_0013;
        @(negedge clk_i);
        load_addr_i = 32'hd0;
        load_data_i = enc_jal(-32'sh98);  // loop now detours 0xd0 -> 0x38
        @(negedge clk_i);
        load_we_i = 1'b0;
        repeat (LOAD_CYC) @(negedge clk_i);
        if (drop_count == 0) report_failure("pkt_valid_o never dropped during the load burst");
        if (!seen[7]) report_failure("rewritten JAL at 0xd0 never reached 0x38");
        $display("load test done: %0d errors", err_count - errs_before);

        repeat (2) @(negedge clk_i);
        $display("checks %0d, errors %0d", check_count, err_count);
        if (err_count == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dv/frontend_assertions.sv */
// Concurrent checks on the front end, bound into frontend_top.
// Active only outside reset.

`timescale 1ns/1ns
`default_nettype none

module frontend_assertions (
    input wire                        clk_i,
    input wire                        rst_n_i,
    input wire                        load_we_i,
    input wire                        stall_i,
    input wire                        rvalid_i,
    input wire fetch_pkg::inst_t      rdata0_i,
    input wire fetch_pkg::inst_t      rdata1_i,
    input wire fetch_pkg::fetch_pkt_t pkt_i,
    input wire                        pkt_valid_i
);

    // load port owns the memory, no read goes out and the read data stays
    a_no_read_on_load: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        load_we_i |=> (!rvalid_i && $stable(rdata0_i) && $stable(rdata1_i)))
        else $error("fetch read performed while load_we_i high");

    // JAL in slot 0 kills slot 1
    a_jal0_kills_slot1: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pkt_valid_i && pkt_i.inst0[6:0] == bpu_pkg::OPC_JAL) |-> !pkt_i.valid1)
        else $error("valid1 high behind a slot 0 JAL");

    // decode hold keeps the packet on the output
    a_hold_under_stall: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (pkt_valid_i && stall_i) |=> (pkt_valid_i && $stable(pkt_i)))
        else $error("packet moved while stall_i high");

endmodule

bind frontend_top frontend_assertions u_frontend_assertions (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .load_we_i   (load_we_i),
    .stall_i     (stall_i),
    .rvalid_i    (rvalid),
    .rdata0_i    (rdata0),
    .rdata1_i    (rdata1),
    .pkt_i       (pkt_o),
    .pkt_valid_i (pkt_valid_o)
);

`default_nettype wire

/* logic/frontend_top.sv */
// Two-wide fetch front end: PC generator, static predictor, memory arbiter
// and instruction RAM. The program is written through the load port; loads
// take the memory from fetch, so no packets come out while writes go on.
// RESET_PC is the first fetch address and IMEM_DEPTH is the RAM size in words.

`timescale 1ns/1ns
`default_nettype none

module frontend_top #(
    parameter fetch_pkg::addr_t RESET_PC   = '0,
    parameter int               IMEM_DEPTH = 1024
) (
    input  wire                   clk_i,
    input  wire                   rst_n_i,
    input  wire                   load_we_i,
    input  wire fetch_pkg::addr_t load_addr_i,
    input  wire fetch_pkg::inst_t load_data_i,
    input  wire                   stall_i,      // decode hold
    output fetch_pkg::fetch_pkt_t pkt_o,
    output logic                  pkt_valid_o
);

    localparam int IDX_W = $clog2(IMEM_DEPTH);

    wire fetch_pkg::fetch_req_t fetch_req;
    wire                        fetch_gnt;
    wire                        rvalid;
    wire                        mem_we;
    wire [IDX_W-1:0]            mem_waddr;
    wire fetch_pkg::inst_t      mem_wdata;
    wire                        mem_re;
    wire [IDX_W-1:0]            mem_raddr;
    wire fetch_pkg::inst_t      rdata0;
    wire fetch_pkg::inst_t      rdata1;
    wire bpu_pkg::bpu_pred_t    pred;
    wire fetch_pkg::inst_t      bpu_inst0;
    wire fetch_pkg::inst_t      bpu_inst1;
    wire fetch_pkg::addr_t      bpu_pc0;
    wire fetch_pkg::addr_t      bpu_pc1;
    wire                        bpu_valid0;
    wire                        bpu_valid1;

    fetch_pc_gen #(
        .RESET_PC (RESET_PC)
    ) u_fetch_pc_gen (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .stall_i      (stall_i),
        .fetch_req_o  (fetch_req),
        .fetch_gnt_i  (fetch_gnt),
        .rvalid_i     (rvalid),
        .rdata0_i     (rdata0),
        .rdata1_i     (rdata1),
        .pred_i       (pred),
        .bpu_inst0_o  (bpu_inst0),
        .bpu_inst1_o  (bpu_inst1),
        .bpu_pc0_o    (bpu_pc0),
        .bpu_pc1_o    (bpu_pc1),
        .bpu_valid0_o (bpu_valid0),
        .bpu_valid1_o (bpu_valid1),
        .pkt_o        (pkt_o),
        .pkt_valid_o  (pkt_valid_o)
    );

    static_bpu u_static_bpu (
        .inst0_i  (bpu_inst0),
        .inst1_i  (bpu_inst1),
        .valid0_i (bpu_valid0),
        .valid1_i (bpu_valid1),
        .pc0_i    (bpu_pc0),
        .pc1_i    (bpu_pc1),
        .stall_i  (stall_i),
        .pred_o   (pred)
    );

    imem_arbiter #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_imem_arbiter (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .load_we_i   (load_we_i),
        .load_addr_i (load_addr_i),
        .load_data_i (load_data_i),
        .fetch_req_i (fetch_req),
        .fetch_gnt_o (fetch_gnt),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata),
        .mem_re_o    (mem_re),
        .mem_raddr_o (mem_raddr),
        .rvalid_o    (rvalid)
    );

    inst_mem #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_inst_mem (
        .clk_i    (clk_i),
        .we_i     (mem_we),
        .waddr_i  (mem_waddr),
        .wdata_i  (mem_wdata),
        .re_i     (mem_re),
        .raddr_i  (mem_raddr),
        .rdata0_o (rdata0),
        .rdata1_o (rdata1)
    );

endmodule

`default_nettype wire

/* logic/fetch_pc_gen.sv */
// Fetch PC, read issue and fetch packet formation.
// Each granted cycle fetches pc and advances pc by 8. A taken packet
// redirects pc to its target; the read issued in that same cycle is
// dropped by an epoch tag, which costs one bubble.
// stall_i holds the packet on the output and stops new reads; the
// packet's prediction acts in the first cycle stall_i is low.

`timescale 1ns/1ns
`default_nettype none

module fetch_pc_gen #(
    parameter fetch_pkg::addr_t RESET_PC = '0
) (
    input  wire                     clk_i,
    input  wire                     rst_n_i,
    input  wire                     stall_i,
    output fetch_pkg::fetch_req_t   fetch_req_o,
    input  wire                     fetch_gnt_i,
    input  wire                     rvalid_i,      // words of last cycle's read are back
    input  wire fetch_pkg::inst_t   rdata0_i,
    input  wire fetch_pkg::inst_t   rdata1_i,
    input  wire bpu_pkg::bpu_pred_t pred_i,
    output fetch_pkg::inst_t        bpu_inst0_o,
    output fetch_pkg::inst_t        bpu_inst1_o,
    output fetch_pkg::addr_t        bpu_pc0_o,
    output fetch_pkg::addr_t        bpu_pc1_o,
    output logic                    bpu_valid0_o,
    output logic                    bpu_valid1_o,
    output fetch_pkg::fetch_pkt_t   pkt_o,
    output logic                    pkt_valid_o
);

    typedef enum logic {
        RUN,   // packets follow returned reads
        HOLD   // decode stalled, current packet kept on the output
    } state_t;

    state_t           state_q, state_d;
    fetch_pkg::addr_t pc_q;       // next address to fetch
    fetch_pkg::addr_t ret_pc_q;   // pc0 of the words on rdata
    logic             epoch_q;    // flips on every redirect
    logic             ret_tag_q;  // epoch of the read in flight
    logic             issue;      // read accepted this cycle
    logic             live;       // returned read still on the right path
    logic             redirect;
    logic             taken_raw;  // prediction without the stall mask

    // request every cycle decode can take more
    assign fetch_req_o.re = ~stall_i;
    assign fetch_req_o.pc = pc_q;
    assign issue          = fetch_req_o.re & fetch_gnt_i;

    assign live        = rvalid_i & (ret_tag_q == epoch_q);
    assign pkt_valid_o = (state_q == HOLD) | live;
    assign redirect    = pkt_valid_o & pred_i.taken;  // taken already masked by stall

    always_comb begin
        state_d = state_q;
        case (state_q)
            RUN: begin
                if (live && stall_i) begin
                    state_d = HOLD;  // no reads under stall, rdata stays
                end
            end
            HOLD: begin
                if (!stall_i) begin
                    state_d = RUN;  // packet consumed this cycle
                end
            end
            default: state_d = RUN;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q   <= RUN;
            pc_q      <= RESET_PC;
            epoch_q   <= 1'b0;
            ret_tag_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (redirect) begin
                pc_q    <= pred_i.target;
                epoch_q <= ~epoch_q;  // kills the read issued this cycle
            end else if (issue) begin
                pc_q <= pc_q + fetch_pkg::addr_t'(8);
            end
            if (issue) begin
                ret_tag_q <= epoch_q;
            end
        end
    end

    // pc of the pair now being read
    always_ff @(posedge clk_i) begin
        if (issue) begin
            ret_pc_q <= pc_q;
        end
    end

    // predictor sees the candidate packet
    assign bpu_inst0_o  = rdata0_i;
    assign bpu_inst1_o  = rdata1_i;
    assign bpu_pc0_o    = ret_pc_q;
    assign bpu_pc1_o    = ret_pc_q + fetch_pkg::addr_t'(4);
    assign bpu_valid0_o = pkt_valid_o;
    assign bpu_valid1_o = pkt_valid_o;

    // slot 0 taken in any form, or slot 1 chosen
    assign taken_raw = pred_i.pred_br0 | pred_i.disable1 | pred_i.slot;

    always_comb begin
        pkt_o.pc0         = ret_pc_q;
        pkt_o.inst0       = rdata0_i;
        pkt_o.inst1       = rdata1_i;
        pkt_o.valid0      = pkt_valid_o;
        // slot 1 dropped behind a JAL or a taken branch in slot 0
        pkt_o.valid1      = pkt_valid_o & ~pred_i.disable1
                          & ~(pred_i.pred_br0 & ~pred_i.slot);
        pkt_o.pred_br0    = pred_i.pred_br0;
        pkt_o.pred_br1    = pred_i.pred_br1;
        pkt_o.pred_taken  = taken_raw;  // stable while held
        pkt_o.pred_slot   = pred_i.slot;
        pkt_o.pred_target = pred_i.target;
    end

endmodule

`default_nettype wire

/* logic/inst_mem.sv */
// Word addressed instruction RAM, one write port and a paired read port.
// A read returns words at raddr and raddr+1 (wrapping at the top) one
// cycle later. Outputs hold their value until the next read, so data
// stays put while fetch is stalled. Reads and writes never share a cycle.

`timescale 1ns/1ns
`default_nettype none

module inst_mem #(
    parameter  int IMEM_DEPTH = 1024,
    localparam int IDX_W      = $clog2(IMEM_DEPTH)
) (
    input  wire                   clk_i,
    input  wire                   we_i,
    input  wire [IDX_W-1:0]       waddr_i,
    input  wire fetch_pkg::inst_t wdata_i,
    input  wire                   re_i,
    input  wire [IDX_W-1:0]       raddr_i,
    output fetch_pkg::inst_t      rdata0_o,  // word at raddr
    output fetch_pkg::inst_t      rdata1_o   // word at raddr+1
);

    fetch_pkg::inst_t mem [IMEM_DEPTH];  // program image, filled through the write port

    logic [IDX_W-1:0] raddr_nxt;

    // second word of the pair, wrap on the last entry
    assign raddr_nxt = (raddr_i == IDX_W'(IMEM_DEPTH - 1)) ? '0 : raddr_i + 1'b1;

    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
        if (re_i) begin  // outputs only move on a granted read
            rdata0_o <= mem[raddr_i];
            rdata1_o <= mem[raddr_nxt];
        end
    end

endmodule

`default_nettype wire

/* logic/imem_arbiter.sv */
// Fixed priority arbiter in front of the instruction memory.
// The load port always wins, so a fetch read is refused in any cycle
// with load_we_i high. Byte addresses are cut to word indices, so
// addresses beyond IMEM_DEPTH words alias; IMEM_DEPTH should be a power of two.

`timescale 1ns/1ns
`default_nettype none

module imem_arbiter #(
    parameter  int IMEM_DEPTH = 1024,
    localparam int IDX_W      = $clog2(IMEM_DEPTH)
) (
    input  wire                        clk_i,
    input  wire                        rst_n_i,
    input  wire                        load_we_i,    // one word per cycle
    input  wire fetch_pkg::addr_t      load_addr_i,  // byte address
    input  wire fetch_pkg::inst_t      load_data_i,
    input  wire fetch_pkg::fetch_req_t fetch_req_i,
    output logic                       fetch_gnt_o,  // same cycle grant
    output logic                       mem_we_o,
    output logic [IDX_W-1:0]           mem_waddr_o,
    output fetch_pkg::inst_t           mem_wdata_o,
    output logic                       mem_re_o,
    output logic [IDX_W-1:0]           mem_raddr_o,
    output logic                       rvalid_o      // read data on memory outputs
);

    // write side, passed straight through
    assign mem_we_o    = load_we_i;
    assign mem_waddr_o = load_addr_i[IDX_W+1:2];
    assign mem_wdata_o = load_data_i;

    // read only when the load port is idle
    assign fetch_gnt_o = fetch_req_i.re & ~load_we_i;
    assign mem_re_o    = fetch_gnt_o;
    assign mem_raddr_o = fetch_req_i.pc[IDX_W+1:2];  // word index of slot 0

    // memory has one cycle latency, a grant now means data next cycle
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rvalid_o <= 1'b0;
        end else begin
            rvalid_o <= fetch_gnt_o;
        end
    end

endmodule

`default_nettype wire

/* logic/static_bpu.sv */
// Static predictor for a two-wide fetch packet, purely combinational.
// Backward conditional branches and every JAL are taken, JALR never is.
// Slot 0 wins over slot 1 and a JAL in slot 0 shuts slot 1 off.
// target is only meaningful as a redirect when taken; otherwise it is
// pc+4 of slot 0. stall_i masks taken but no other field.

`timescale 1ns/1ns
`default_nettype none

module static_bpu (
    input  wire fetch_pkg::inst_t  inst0_i,
    input  wire fetch_pkg::inst_t  inst1_i,
    input  wire                    valid0_i,
    input  wire                    valid1_i,
    input  wire fetch_pkg::addr_t  pc0_i,
    input  wire fetch_pkg::addr_t  pc1_i,
    input  wire                    stall_i,   // decode hold, no redirect while high
    output bpu_pkg::bpu_pred_t     pred_o
);

    // B-type offset, bit 0 always zero
    function automatic bpu_pkg::imm_t b_imm(input fetch_pkg::inst_t inst);
        return {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
    endfunction

    // J-type offset, bit 0 always zero
    function automatic bpu_pkg::imm_t j_imm(input fetch_pkg::inst_t inst);
        return {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
    endfunction

    // next pc for one slot, pc+4 when the slot does not redirect
    function automatic fetch_pkg::addr_t slot_target(
        input fetch_pkg::addr_t pc,
        input logic             br,
        input logic             jal,
        input bpu_pkg::imm_t    bimm,
        input bpu_pkg::imm_t    jimm
    );
        bpu_pkg::imm_t off;
        if (br) begin
            off = bimm;
        end else if (jal) begin
            off = jimm;
        end else begin
            off = bpu_pkg::imm_t'(4);
        end
        return pc + off;
    endfunction

    bpu_pkg::opcode_t op0, op1;
    bpu_pkg::imm_t    bimm0, jimm0, bimm1, jimm1;
    logic             is_br0, is_jal0, is_br1, is_jal1;  // raw opcode matches
    logic             br0, jal0, br1, jal1;              // valid predictions
    logic             act1;                              // slot 1 still live
    logic             tk0, tk1;
    logic             from1;                             // slot 1 chosen
    fetch_pkg::addr_t tgt0, tgt1;

    assign op0 = inst0_i[6:0];
    assign op1 = inst1_i[6:0];

    assign is_br0  = (op0 == bpu_pkg::OPC_BRANCH);
    assign is_jal0 = (op0 == bpu_pkg::OPC_JAL);
    assign is_br1  = (op1 == bpu_pkg::OPC_BRANCH);
    assign is_jal1 = (op1 == bpu_pkg::OPC_JAL);

    assign bimm0 = b_imm(inst0_i);
    assign jimm0 = j_imm(inst0_i);
    assign bimm1 = b_imm(inst1_i);
    assign jimm1 = j_imm(inst1_i);

    // slot 0, sign bit of the offset decides backward
    assign br0  = valid0_i & is_br0 & bimm0[31];
    assign jal0 = valid0_i & is_jal0;

    // slot 1 is dead behind a JAL in slot 0
    assign act1 = valid1_i & ~jal0;
    assign br1  = act1 & is_br1 & bimm1[31];
    assign jal1 = act1 & is_jal1;

    assign tk0   = br0 | jal0;
    assign tk1   = br1 | jal1;
    assign from1 = tk1 & ~tk0;  // slot 0 priority

    assign tgt0 = slot_target(pc0_i, br0, jal0, bimm0, jimm0);
    assign tgt1 = slot_target(pc1_i, br1, jal1, bimm1, jimm1);

    assign pred_o.taken    = (tk0 | tk1) & ~stall_i;
    assign pred_o.target   = from1 ? tgt1 : tgt0;
    assign pred_o.slot     = from1;
    assign pred_o.pred_br0 = br0;
    assign pred_o.pred_br1 = br1;
    assign pred_o.disable1 = jal0;

endmodule

`default_nettype wire

/* logic/bpu_pkg.sv */
// Decode constants and result type for the static branch predictor.
// Only the RV32 conditional branch and JAL opcodes are recognised here,
// JALR is never predicted.

`default_nettype none

package bpu_pkg;

    typedef logic [6:0] opcode_t;  // inst[6:0]

    localparam opcode_t OPC_BRANCH = 7'b1100011;  // beq/bne/blt/bge/bltu/bgeu
    localparam opcode_t OPC_JAL    = 7'b1101111;

    // sign extended immediate, same width as an address
    typedef logic [fetch_pkg::XLEN-1:0] imm_t;

    // predictor result for one fetch packet
    typedef struct packed {
        logic             taken;     // redirect now, masked by stall
        fetch_pkg::addr_t target;    // target of chosen slot or its pc+4
        logic             slot;      // chosen slot, 1 only if slot 0 not taken
        logic             pred_br0;  // slot 0 backward branch
        logic             pred_br1;  // slot 1 backward branch, off if slot 1 disabled
        logic             disable1;  // slot 0 holds a valid JAL
    } bpu_pred_t;

endpackage

`default_nettype wire

/* logic/fetch_pkg.sv */
// Fetch datapath types shared by the PC generator, arbiter, memory and top level.
// Addresses are byte addresses; instructions are 32-bit and word aligned.
// A fetch covers two consecutive words, pc and pc+4. No compressed support.

`default_nettype none

package fetch_pkg;

    localparam int XLEN = 32;  // data and address width

    typedef logic [XLEN-1:0] addr_t;  // byte address of an instruction
    typedef logic [XLEN-1:0] inst_t;  // raw instruction word

    // read request from the PC generator, memory returns words at pc and pc+4
    typedef struct packed {
        logic  re;  // read strobe, level while a fetch is wanted
        addr_t pc;  // pc of slot 0
    } fetch_req_t;

    // fetch packet as seen by decode
    typedef struct packed {
        addr_t pc0;          // pc of slot 0, slot 1 sits at pc0+4
        inst_t inst0;
        inst_t inst1;
        logic  valid0;
        logic  valid1;       // low after a taken slot 0
        logic  pred_br0;     // slot 0 is a conditional branch predicted taken
        logic  pred_br1;     // same for slot 1
        logic  pred_taken;   // decoded prediction, not masked by stall
        logic  pred_slot;    // 0 = slot 0 redirects, 1 = slot 1 redirects
        addr_t pred_target;  // taken target, else pc0+4
    } fetch_pkt_t;

endpackage

`default_nettype wire
